//--- files.f
design/sd_pkg.sv
design/spi_byte_engine.sv
design/autotest_ctrl.sv
design/sd_block_reader.sv
design/seg_display.sv
design/sd_autotest_top.sv
test/sd_card_model.sv
test/tb_sd_autotest.sv

//--- test/tb_sd_autotest.sv
// Testbench for the SD autotest top level with the card model on the SPI pins, run as the sim top
`timescale 1ns/1ps

module tb_sd_autotest import sd_pkg::*; ();

  // Worst run is three blocks at speed 3, about 105k clocks, and there are seven runs
  localparam int CYCLE_LIMIT = 1_000_000;

  logic        clk;
  logic        rst_n;
  logic [15:0] switch_i;
  logic [15:0] leds_o;
  logic [6:0]  seg;
  logic [7:0]  an;
  logic        cs;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic        sd_reset;
  logic        sd_dat_1;
  logic        sd_dat_2;
  logic        never_ready;
  logic [31:0] rng_state;
  logic [31:0] disp_expect;
  logic        disp_check_en;
  int          cycles = 0;
  int          err_count;
  int          tests_run;
  int          tests_failed;

  sd_autotest_top UUT (
    .sys_clk_pad_i(clk), .rst_n(rst_n), .switch_i(switch_i), .leds_o(leds_o),
    .seg(seg), .AN(an), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .SD_RESET(sd_reset), .SD_DAT_1(sd_dat_1), .SD_DAT_2(sd_dat_2)
  );
  defparam UUT.display_inst.DIGIT_SHIFT = 4;       // A full digit sweep takes 128 clocks

  sd_card_model card (
    .rst_n(rst_n), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso), .never_ready(never_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped: the cycle limit of %0d was reached before the tests ended",
               CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte o of block b holds (b*7 + o) mod 256
  function automatic logic [31:0] expected_sum(input int n, input logic [31:0] first);
    logic [31:0] sum;
    logic [31:0] blk;
    sum = '0;
    for (int k = 0; k < n; k++) begin
      blk = first + k;
      for (int o = 0; o < BLOCK_BYTES; o++) begin
        sum = sum + ((blk * 7 + o) % 256);
      end
    end
    return sum;
  endfunction

  function automatic logic [6:0] hex_segments(input logic [3:0] nib);
    logic [6:0] lit;                               // Active high, gfedcba
    case (nib)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("ERR @%0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("pass  %s", name);
    end else begin
      tests_failed++;
      $display("fail  %s", name);
    end
  endtask

  // Resets the board with new switch settings and waits for a result on the LEDs
  task automatic run_read(input int n, input int speed, input logic multi, input logic stall);
    @(negedge clk);
    rst_n       = 1'b0;
    switch_i    = {multi, 5'(speed), 10'(n)};
    never_ready = stall;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    do begin
      @(negedge clk);
    end while (leds_o == 16'h0);
  endtask

  always @(negedge clk) begin
    if (disp_check_en) begin
      check($countones(~an), 1, "number of active anodes");
      for (int d = 0; d < 8; d++) begin
        if (!an[d]) begin
          check(seg, hex_segments(disp_expect[4*d +: 4]), "segments of the lit digit");
        end
      end
    end
  end

  initial begin
    int   errs;
    int   n;
    int   speed;
    logic multi;
    rst_n         = 1'b0;
    switch_i      = '0;
    never_ready   = 1'b0;
    disp_check_en = 1'b0;
    disp_expect   = '0;
    rng_state     = 32'h796ebbd0;
    err_count     = 0;
    tests_run     = 0;
    tests_failed  = 0;

    errs = err_count;
    run_read(1, 0, 1'b0, 1'b0);
    check(leds_o, expected_sum(1, START_BLOCK) & 32'hFFFF, "LEDs after a single-block read");
    check(card.cmd17_count, 1, "CMD17 count");
    check(card.cmd18_count, 0, "CMD18 count");
    report_test("single-block read", errs);

    errs = err_count;
    check(card.powerup_edges >= POWERUP_CLOCKS, 1, "enough power-up clocks with cs high");
    check(card.first_cmd, CMD_GO_IDLE, "index of the first command");
    report_test("power-up clocks and first command", errs);

    errs = err_count;
    check(sd_reset, 1'b0, "SD_RESET pin");
    check(sd_dat_1, 1'b1, "SD_DAT_1 pin");
    check(sd_dat_2, 1'b1, "SD_DAT_2 pin");
    report_test("tied card pins", errs);

    errs = err_count;
    run_read(3, 1, 1'b1, 1'b0);
    check(leds_o, expected_sum(3, START_BLOCK) & 32'hFFFF, "LEDs after a multi-block read");
    check(card.cmd18_count, 1, "CMD18 count");
    check(card.cmd18_arg, START_BLOCK, "CMD18 argument");
    check(card.cmd12_count, 1, "CMD12 count");
    check(card.cmd17_count, 0, "CMD17 count");
    report_test("multi-block read", errs);

    errs = err_count;
    disp_expect   = expected_sum(3, START_BLOCK);
    disp_check_en = 1'b1;
    repeat (256) @(negedge clk);                   // Two full sweeps of the eight digits
    disp_check_en = 1'b0;
    report_test("seven-segment display", errs);

    for (int mode = 0; mode < 2; mode++) begin
      for (int rep = 0; rep < 2; rep++) begin
        errs      = err_count;
        multi     = (mode == 1);
        rng_state = xorshift32(rng_state);
        n         = 1 + rng_state % 3;
        rng_state = xorshift32(rng_state);
        speed     = rng_state % 4;
        run_read(n, speed, multi, 1'b0);
        check(leds_o, expected_sum(n, START_BLOCK) & 32'hFFFF, "LEDs after a random read");
        if (multi) begin
          check(card.cmd18_count, 1, "CMD18 count");
          check(card.cmd12_count, 1, "CMD12 count");
        end else begin
          check(card.cmd17_count, n, "CMD17 count");
        end
        report_test($sformatf("random read of %0d block(s) at speed %0d by %s", n, speed,
                              multi ? "CMD18" : "CMD17"), errs);
      end
    end

    errs = err_count;
    run_read(1, 0, 1'b0, 1'b1);
    check(leds_o, 32'hEEEE, "LEDs after a failed init");
    check(card.cmd17_count, 0, "CMD17 count after a failed init");
    repeat (200) begin
      @(negedge clk);
      check(cs, 1'b1, "cs after a failed init");
    end
    never_ready = 1'b0;
    report_test("card that never leaves idle", errs);

    $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- test/sd_card_model.sv
// Behavioral SPI-mode SD card for the testbench, answering init and read commands with rule-based data
`timescale 1ns/1ps

module sd_card_model import sd_pkg::*; (
  input  logic rst_n,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  input  logic never_ready                         // Keeps ACMD41 answering 0x01
);

  logic [7:0]    rx_sr;
  logic [7:0]    tx_sr;                            // Bits still to be sent in the current byte
  int            bit_cnt;
  int            cmd_pos;                          // Command bytes captured so far
  sd_cmd_frame_u frame;
  logic [7:0]    out_q[$];
  logic          streaming;                        // CMD18 is active until CMD12
  logic [31:0]   stream_blk;
  int            acmd41_seen;

  // Traffic seen on the bus, read by the testbench
  int            powerup_edges;
  logic          cs_fell;
  int            cmd_count;
  logic [5:0]    first_cmd;
  int            cmd17_count;
  int            cmd18_count;
  int            cmd12_count;
  logic [31:0]   cmd18_arg;

  task automatic clear_state();
    bit_cnt       = 0;
    cmd_pos       = 0;
    out_q.delete();
    streaming     = 1'b0;
    stream_blk    = '0;
    acmd41_seen   = 0;
    rx_sr         = 8'hFF;
    tx_sr         = 8'hFF;
    miso          = 1'b1;
    powerup_edges = 0;
    cs_fell       = 1'b0;
    cmd_count     = 0;
    first_cmd     = 6'h3F;
    cmd17_count   = 0;
    cmd18_count   = 0;
    cmd12_count   = 0;
    cmd18_arg     = '0;
  endtask

  task automatic push_r1(input logic [7:0] r1);
    out_q.push_back(8'hFF);                        // One byte of response delay
    out_q.push_back(r1);
  endtask

  task automatic queue_block(input logic [31:0] blk);
    out_q.push_back(8'hFF);
    out_q.push_back(8'hFF);
    out_q.push_back(8'hFE);                        // Start token
    for (int o = 0; o < BLOCK_BYTES; o++) begin
      out_q.push_back(8'((blk * 32'd7) + 32'(o)));
    end
    out_q.push_back(8'hA5);                        // CRC bytes that the host drops
    out_q.push_back(8'h5A);
  endtask

  task automatic run_command();
    logic [5:0]  idx;
    logic [31:0] arg;
    idx = frame.fields.index;
    arg = frame.fields.arg;
    cmd_count++;
    if (cmd_count == 1) begin
      first_cmd = idx;
    end
    case (idx)
      CMD_GO_IDLE: begin
        acmd41_seen = 0;
        streaming   = 1'b0;
        out_q.delete();
        push_r1(8'h01);
      end
      CMD_APP: push_r1(8'h01);
      ACMD_OP_COND: begin
        acmd41_seen++;
        push_r1((never_ready || acmd41_seen < 2) ? 8'h01 : 8'h00); // Ready on the second try
      end
      CMD_READ_SINGLE: begin
        cmd17_count++;
        push_r1(8'h00);
        queue_block(arg);
      end
      CMD_READ_MULTI: begin
        cmd18_count++;
        cmd18_arg  = arg;
        push_r1(8'h00);
        streaming  = 1'b1;
        stream_blk = arg;
      end
      CMD_STOP: begin
        cmd12_count++;
        streaming = 1'b0;
        out_q.delete();                            // Abandon the block being streamed
        push_r1(8'h00);
      end
      default: push_r1(8'h04);                     // Illegal command
    endcase
  endtask

  task automatic take_byte(input logic [7:0] b);
    if (cmd_pos == 0 && b[7:6] == 2'b01) begin
      frame.bytes[0] = b;
      cmd_pos        = 1;
    end else if (cmd_pos != 0) begin
      frame.bytes[cmd_pos] = b;
      cmd_pos++;
      if (cmd_pos == 6) begin
        cmd_pos = 0;
        run_command();
      end
    end
  endtask

  initial clear_state();

  always @(negedge rst_n) clear_state();

  always @(negedge cs) begin
    if (rst_n) begin
      cs_fell = 1'b1;
      bit_cnt = 0;
      tx_sr   = 8'hFF;
      miso    = 1'b1;
    end
  end

  always @(posedge sclk) begin
    if (rst_n && cs && !cs_fell) begin
      powerup_edges++;
    end else if (rst_n && !cs) begin
      rx_sr = {rx_sr[6:0], mosi};
      bit_cnt++;
    end
  end

  // MISO changes on the falling edge so it is settled before the host samples it
  always @(negedge sclk) begin
    if (rst_n && !cs) begin
      if (bit_cnt == 8) begin
        bit_cnt = 0;
        take_byte(rx_sr);
        if (out_q.size() == 0 && streaming) begin
          queue_block(stream_blk);
          stream_blk++;
        end
        tx_sr = (out_q.size() != 0) ? out_q.pop_front() : 8'hFF;
      end
      miso  = tx_sr[7];
      tx_sr = {tx_sr[6:0], 1'b1};
    end
  end

endmodule

//--- design/sd_autotest_top.sv
// Board top level for the SD card SPI self-test, wiring controller, reader, SPI engine and display
`timescale 1ns/1ps

module sd_autotest_top import sd_pkg::*; (
  input  logic        sys_clk_pad_i,
  input  logic        rst_n,
  input  logic [15:0] switch_i,
  output logic [15:0] leds_o,
  output logic [6:0]  seg,
  output logic [7:0]  AN,
  output logic        cs,
  output logic        sclk,
  output logic        mosi,
  input  logic        miso,
  output logic        SD_RESET,
  output logic        SD_DAT_1,
  output logic        SD_DAT_2
);

  logic                       uut_ctrl_mux;
  logic                       uut_start;
  logic [N_BLOCK_SIZE-1:0]    uut_n_blocks;
  logic [SCLK_SPEED_SIZE-1:0] uut_sclk_speed;
  logic [CMD18_SIZE-1:0]      uut_cmd18;
  logic                       uut_finish;
  logic                       uut_error;
  logic [31:0]                uut_checksum;
  logic [31:0]                debug_data;

  logic       ctrl_byte_start;
  logic       ctrl_cs;
  logic       rd_byte_start;
  logic       rd_cs;
  logic [7:0] rd_tx_byte;
  logic       eng_byte_start;
  logic [7:0] eng_tx_byte;
  logic [7:0] eng_rx_byte;
  logic       eng_byte_done;

  assign SD_RESET = 1'b0;
  assign SD_DAT_1 = 1'b1;                          // Unused data lines held high in SPI mode
  assign SD_DAT_2 = 1'b1;

  // The controller only ever sends 0xFF while it owns the bus
  assign eng_byte_start = uut_ctrl_mux ? rd_byte_start : ctrl_byte_start;
  assign eng_tx_byte    = uut_ctrl_mux ? rd_tx_byte    : 8'hFF;
  assign cs             = uut_ctrl_mux ? rd_cs         : ctrl_cs;

  autotest_ctrl autotest_inst (
    .clk(sys_clk_pad_i), .rst_n(rst_n), .switch_i(switch_i),
    .uut_ctrl_mux(uut_ctrl_mux), .uut_start(uut_start),
    .uut_n_blocks(uut_n_blocks), .uut_sclk_speed(uut_sclk_speed), .uut_cmd18(uut_cmd18),
    .uut_finish(uut_finish), .uut_error(uut_error), .uut_checksum(uut_checksum),
    .byte_start(ctrl_byte_start), .byte_done(eng_byte_done), .cs_ctrl(ctrl_cs),
    .leds_o(leds_o), .debug(debug_data)
  );

  sd_block_reader reader_inst (
    .clk(sys_clk_pad_i), .rst_n(rst_n), .start(uut_start),
    .n_blocks(uut_n_blocks), .cmd18(uut_cmd18),
    .finish(uut_finish), .error(uut_error), .checksum(uut_checksum),
    .cs(rd_cs), .byte_start(rd_byte_start), .tx_byte(rd_tx_byte),
    .byte_done(eng_byte_done), .rx_byte(eng_rx_byte)
  );

  spi_byte_engine spi_inst (
    .clk(sys_clk_pad_i), .rst_n(rst_n), .sclk_speed(uut_sclk_speed),
    .byte_start(eng_byte_start), .tx_byte(eng_tx_byte), .rx_byte(eng_rx_byte),
    .busy(), .byte_done(eng_byte_done),
    .sclk(sclk), .mosi(mosi), .miso(miso)
  );

  seg_display display_inst (
    .clk(sys_clk_pad_i), .rst_n(rst_n), .din(debug_data), .an(AN), .seg(seg)
  );

endmodule

//--- design/seg_display.sv
// Multiplexed eight-digit seven-segment driver that shows a 32-bit word in hex
`timescale 1ns/1ps

module seg_display #(
  parameter int DIGIT_SHIFT = 16                   // Each digit is lit for 2**DIGIT_SHIFT clocks
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] din,
  output logic [7:0]  an,
  output logic [6:0]  seg
);

  logic [DIGIT_SHIFT+2:0] refresh_cnt;
  logic [2:0]             digit;
  logic [3:0]             nibble;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      refresh_cnt <= '0;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  assign digit  = refresh_cnt[DIGIT_SHIFT+2:DIGIT_SHIFT];
  assign nibble = din[digit*4 +: 4];
  assign an     = ~(8'b1 << digit);                // One anode low at a time

  // Segment order is gfedcba and a low bit lights the segment
  always_comb begin
    case (nibble)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'hA:    seg = 7'b0001000;
      4'hB:    seg = 7'b0000011;
      4'hC:    seg = 7'b1000110;
      4'hD:    seg = 7'b0100001;
      4'hE:    seg = 7'b0000110;
      default: seg = 7'b0001110;                   // F
    endcase
  end

endmodule

//--- design/sd_block_reader.sv
// SD card SPI-mode reader that initialises the card, reads blocks by CMD17 or CMD18 and sums the data
`timescale 1ns/1ps

module sd_block_reader import sd_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [N_BLOCK_SIZE-1:0] n_blocks,
  input  logic [CMD18_SIZE-1:0]   cmd18,
  output logic                    finish,
  output logic                    error,
  output logic [31:0]             checksum,
  output logic                    cs,
  output logic                    byte_start,
  output logic [7:0]              tx_byte,
  input  logic                    byte_done,
  input  logic [7:0]              rx_byte
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CMD,
    S_R1,
    S_TOKEN,
    S_DATA,
    S_CRC,
    S_FIN
  } state_t;

  state_t                          state;
  sd_cmd_frame_u                   cmd_frame;
  logic                            pend;           // A byte exchange is in flight
  logic [7:0]                      tx_next;
  logic [$clog2(BLOCK_BYTES)-1:0]  byte_cnt;
  logic [$clog2(TOKEN_TRIES)-1:0]  poll_cnt;
  logic [$clog2(INIT_TRIES)-1:0]   init_cnt;
  logic [N_BLOCK_SIZE-1:0]         blk_cnt;

  function automatic sd_cmd_frame_u make_frame(input logic [5:0] idx, input logic [31:0] arg);
    sd_cmd_frame_u f;
    f.fields.start_tx = 2'b01;
    f.fields.index    = idx;
    f.fields.arg      = arg;
    f.fields.crc_stop = (idx == CMD_GO_IDLE) ? 8'h95 : 8'h01; // Only CMD0 needs a real CRC
    return f;
  endfunction

  always_comb begin
    if (state == S_CMD) begin
      tx_next = cmd_frame.bytes[byte_cnt[2:0]];
    end else begin
      tx_next = 8'hFF;                             // Clock the card while polling or reading
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      pend       <= 1'b0;
      byte_start <= 1'b0;
      cs         <= 1'b1;
      finish     <= 1'b0;
      error      <= 1'b0;
      checksum   <= '0;
      byte_cnt   <= '0;
      poll_cnt   <= '0;
      init_cnt   <= '0;
      blk_cnt    <= '0;
    end else begin
      byte_start <= 1'b0;
      if (state == S_IDLE) begin
        if (start) begin
          cs        <= 1'b0;
          cmd_frame <= make_frame(CMD_GO_IDLE, 32'h0);
          byte_cnt  <= '0;
          state     <= S_CMD;
        end
      end else if (state == S_FIN) begin
        finish <= 1'b1;
        cs     <= 1'b1;
      end else if (!pend) begin
        byte_start <= 1'b1;
        tx_byte    <= tx_next;
        pend       <= 1'b1;
      end else if (byte_done) begin
        pend <= 1'b0;
        case (state)
          S_CMD: begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 3'd5) begin
              poll_cnt <= '0;
              state    <= S_R1;
            end
          end
          S_R1: begin
            if (rx_byte[7]) begin                  // Card has not answered yet
              poll_cnt <= poll_cnt + 1'b1;
              if (poll_cnt == $bits(poll_cnt)'(R1_TRIES - 1)) begin
                error <= 1'b1;
                state <= S_FIN;
              end
            end else begin
              byte_cnt <= '0;
              poll_cnt <= '0;
              state    <= S_CMD;
              case (cmd_frame.fields.index)
                CMD_GO_IDLE: begin
                  cmd_frame <= make_frame(CMD_APP, 32'h0);
                  if (rx_byte != 8'h01) begin
                    error <= 1'b1;
                    state <= S_FIN;
                  end
                end
                CMD_APP: cmd_frame <= make_frame(ACMD_OP_COND, 32'h4000_0000);
                ACMD_OP_COND: begin
                  if (rx_byte == 8'h00) begin
                    cmd_frame <= make_frame(cmd18[0] ? CMD_READ_MULTI : CMD_READ_SINGLE,
                                            START_BLOCK);
                    if (n_blocks == '0) state <= S_FIN;
                  end else if (rx_byte == 8'h01 &&
                               init_cnt != $bits(init_cnt)'(INIT_TRIES - 1)) begin
                    init_cnt  <= init_cnt + 1'b1;  // Card still idle so ask again
                    cmd_frame <= make_frame(CMD_APP, 32'h0);
                  end else begin
                    error <= 1'b1;
                    state <= S_FIN;
                  end
                end
                CMD_READ_SINGLE, CMD_READ_MULTI: begin
                  state <= (rx_byte == 8'h00) ? S_TOKEN : S_FIN;
                  error <= (rx_byte != 8'h00);
                end
                default: state <= S_FIN;           // R1 of CMD12 ends the run
              endcase
            end
          end
          S_TOKEN: begin
            poll_cnt <= poll_cnt + 1'b1;
            if (rx_byte == 8'hFE) begin
              byte_cnt <= '0;
              state    <= S_DATA;
            end else if (poll_cnt == $bits(poll_cnt)'(TOKEN_TRIES - 1)) begin
              error <= 1'b1;
              state <= S_FIN;
            end
          end
          S_DATA: begin
            checksum <= checksum + {24'h0, rx_byte};
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == $bits(byte_cnt)'(BLOCK_BYTES - 1)) begin
              byte_cnt <= '0;
              state    <= S_CRC;
            end
          end
          default: begin                           // S_CRC discards two bytes
            byte_cnt <= byte_cnt + 1'b1;
            poll_cnt <= '0;
            if (byte_cnt[0]) begin
              byte_cnt <= '0;
              blk_cnt  <= blk_cnt + 1'b1;
              if (blk_cnt == n_blocks - 1'b1) begin
                cmd_frame <= make_frame(CMD_STOP, 32'h0);
                state     <= cmd18[0] ? S_CMD : S_FIN;
              end else if (cmd18[0]) begin
                state <= S_TOKEN;                  // Card streams the next block
              end else begin
                cmd_frame <= make_frame(CMD_READ_SINGLE, START_BLOCK + blk_cnt + 1'b1);
                state     <= S_CMD;
              end
            end
          end
        endcase
      end
    end
  end

  // Card must stay deselected for good once the run is over
  cs_idle_a: assert property (@(posedge clk) disable iff (!rst_n) finish |-> cs);

endmodule

//--- design/autotest_ctrl.sv
// Autotest FSM that sends the card power-up clocks, hands the SPI bus to the reader and keeps the result
`timescale 1ns/1ps

module autotest_ctrl import sd_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [15:0]                switch_i,
  output logic                       uut_ctrl_mux,
  output logic                       uut_start,
  output logic [N_BLOCK_SIZE-1:0]    uut_n_blocks,
  output logic [SCLK_SPEED_SIZE-1:0] uut_sclk_speed,
  output logic [CMD18_SIZE-1:0]      uut_cmd18,
  input  logic                       uut_finish,
  input  logic                       uut_error,
  input  logic [31:0]                uut_checksum,
  output logic                       byte_start,
  input  logic                       byte_done,
  output logic                       cs_ctrl,
  output logic [15:0]                leds_o,
  output logic [31:0]                debug
);

  typedef enum logic [2:0] {
    S_POWERUP,
    S_HANDOVER,
    S_START,
    S_WAIT,
    S_DONE
  } state_t;

  state_t state;
  logic   pu_started;                              // First dummy byte has been requested
  logic [$clog2(POWERUP_BYTES)-1:0] pu_cnt;

  assign cs_ctrl = 1'b1;                           // Card stays deselected during power-up
  assign leds_o  = debug[15:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= S_POWERUP;
      pu_started     <= 1'b0;
      pu_cnt         <= '0;
      uut_ctrl_mux   <= 1'b0;
      uut_start      <= 1'b0;
      byte_start     <= 1'b0;
      debug          <= '0;
      uut_n_blocks   <= N_BLOCK_SIZE'(switch_i[9:0]); // Settings taken as reset releases
      uut_sclk_speed <= switch_i[14:10];
      uut_cmd18      <= switch_i[15];
    end else begin
      byte_start <= 1'b0;
      uut_start  <= 1'b0;
      case (state)
        S_POWERUP: begin
          if (!pu_started) begin
            byte_start <= 1'b1;
            pu_started <= 1'b1;
          end else if (byte_done) begin
            if (pu_cnt == $bits(pu_cnt)'(POWERUP_BYTES - 1)) begin
              state <= S_HANDOVER;
            end else begin
              pu_cnt     <= pu_cnt + 1'b1;
              byte_start <= 1'b1;                  // Next 0xFF right after the last one
            end
          end
        end
        S_HANDOVER: begin
          uut_ctrl_mux <= 1'b1;                    // Reader owns the pins from here on
          state        <= S_START;
        end
        S_START: begin
          uut_start <= 1'b1;
          state     <= S_WAIT;
        end
        S_WAIT: begin
          if (uut_finish) begin
            debug <= uut_error ? 32'hEEEE_EEEE : uut_checksum;
            state <= S_DONE;
          end
        end
        default: begin
          state <= S_DONE;                         // One run per reset
        end
      endcase
    end
  end

  // Bus ownership must never return to the controller within a run
  mux_hold_a: assert property (@(posedge clk) disable iff (!rst_n) !$fell(uut_ctrl_mux));

endmodule

//--- design/spi_byte_engine.sv
// Mode-0 SPI byte shifter with a programmable SCLK divider, shared by the controller and the reader
`timescale 1ns/1ps

module spi_byte_engine import sd_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [SCLK_SPEED_SIZE-1:0] sclk_speed,
  input  logic                       byte_start,
  input  logic [7:0]                 tx_byte,
  output logic [7:0]                 rx_byte,
  output logic                       busy,
  output logic                       byte_done,
  output logic                       sclk,
  output logic                       mosi,
  input  logic                       miso
);

  logic [SCLK_SPEED_SIZE-1:0] div_cnt;            // Clocks spent in the current SCLK half
  logic [2:0]                 bit_cnt;
  logic [7:0]                 tx_sr;
  logic [7:0]                 rx_sr;

  assign rx_byte = rx_sr;                          // Complete once byte_done pulses

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      byte_done <= 1'b0;
      sclk      <= 1'b0;
      mosi      <= 1'b1;
      div_cnt   <= '0;
      bit_cnt   <= '0;
    end else begin
      byte_done <= 1'b0;
      if (!busy) begin
        if (byte_start) begin
          busy    <= 1'b1;
          div_cnt <= '0;
          bit_cnt <= '0;
          mosi    <= tx_byte[7];                   // MSB set up before the first rising edge
          tx_sr   <= {tx_byte[6:0], 1'b1};
        end
      end else if (div_cnt != sclk_speed) begin
        div_cnt <= div_cnt + 1'b1;
      end else begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (!sclk) begin
          rx_sr <= {rx_sr[6:0], miso};             // Sample on the rising edge
        end else if (bit_cnt == 3'd7) begin
          busy      <= 1'b0;
          byte_done <= 1'b1;
          mosi      <= 1'b1;                       // Back to idle after the eighth bit
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          mosi    <= tx_sr[7];                     // Shift out on the falling edge
          tx_sr   <= {tx_sr[6:0], 1'b1};
        end
      end
    end
  end

  // A new request while shifting would corrupt the byte in flight
  no_overlap_a: assert property (@(posedge clk) disable iff (!rst_n) !(byte_start && busy));

endmodule

//--- design/sd_pkg.sv
// Shared widths, SD command constants and the SPI command frame type for the SD autotest design
package sd_pkg;

  localparam int N_BLOCK_SIZE    = 32;             // Width of the block count
  localparam int SCLK_SPEED_SIZE = 5;              // Width of the SCLK divider setting
  localparam int CMD18_SIZE      = 1;              // Width of the read mode select
  localparam logic [31:0] START_BLOCK = 32'h0010_0000; // First block read by the test

  localparam int POWERUP_CLOCKS = 80;              // SCLK cycles with cs high before CMD0
  localparam int POWERUP_BYTES  = POWERUP_CLOCKS / 8;
  localparam int BLOCK_BYTES    = 512;
  localparam int R1_TRIES       = 8;               // Bytes polled for an R1 response
  localparam int TOKEN_TRIES    = 4096;            // Bytes polled for the 0xFE data token
  localparam int INIT_TRIES     = 256;             // CMD55/ACMD41 rounds before giving up

  localparam logic [5:0] CMD_GO_IDLE     = 6'd0;
  localparam logic [5:0] CMD_STOP        = 6'd12;
  localparam logic [5:0] CMD_READ_SINGLE = 6'd17;
  localparam logic [5:0] CMD_READ_MULTI  = 6'd18;
  localparam logic [5:0] CMD_APP         = 6'd55;
  localparam logic [5:0] ACMD_OP_COND    = 6'd41;

  typedef struct packed {
    logic [1:0]  start_tx;                         // Always 2'b01
    logic [5:0]  index;
    logic [31:0] arg;
    logic [7:0]  crc_stop;                         // CRC7 and the stop bit
  } sd_cmd_fields_t;

  // Same 48 bits seen as fields or as the six bytes on the wire
  typedef union packed {
    sd_cmd_fields_t  fields;
    logic [0:5][7:0] bytes;                        // Element 0 is the first byte sent
  } sd_cmd_frame_u;

endpackage
